// ==== cgra_defs.svh ====
`ifndef CGRA_DEFS_SVH
`define CGRA_DEFS_SVH

// Host memory side.
`define CGRA_NUM_CH 4
`define CGRA_MEM_W 64

// Fabric side, one PE per lane.
`define CGRA_NUM_LANES 4
`define CGRA_ITEM_W 16

// Fetch FIFO depth in items.
// Two full words fit.
`define CGRA_FIFO_DEPTH 8

`endif

// ==== cgra_cfg_pkg.sv ====
`default_nettype none

`include "cgra_defs.svh"

package cgra_cfg_pkg;

  // Operation applied by a PE to its source item.
  typedef enum logic [2:0] {
    OP_PASS = 3'd0,
    OP_ADD  = 3'd1,
    OP_SUB  = 3'd2,
    OP_XOR  = 3'd3
  } cgra_op_e;

  // Opcode in bits 2:0, source lane in 4:3, constant in 15:8.
  // Bits 7:5 are reserved.
  typedef logic [15:0] pe_cfg_t;

  // One bit per memory channel.
  typedef logic [`CGRA_NUM_CH-1:0] ch_mask_t;

endpackage

`default_nettype wire

// ==== cgra_data_pkg.sv ====
`default_nettype none

`include "cgra_defs.svh"

package cgra_data_pkg;

  typedef logic [`CGRA_MEM_W-1:0] mem_word_t;
  typedef logic [`CGRA_ITEM_W-1:0] item_t;

  typedef enum logic [1:0] {
    CONF_IDLE,
    CONF_REQ,
    CONF_WAIT,
    CONF_DONE
  } conf_state_e;

  typedef enum logic [1:0] {
    EXEC_IDLE,
    EXEC_RUN,
    EXEC_DRAIN,
    EXEC_DONE
  } exec_state_e;

endpackage

`default_nettype wire

// ==== fabric_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

interface fabric_ctrl_if;
  import cgra_cfg_pkg::*;

  pe_cfg_t [`CGRA_NUM_LANES-1:0] pe_cfg;
  logic cfg_valid;
  logic fabric_en;
  logic fabric_idle;

  modport conf (output pe_cfg, output cfg_valid);

  modport exec (output fabric_en, input fabric_idle);

  modport fabric (input pe_cfg, input cfg_valid, input fabric_en, output fabric_idle);

endinterface

`default_nettype wire

// ==== fetch_data.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module fetch_data (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           en,
  input  wire                           available_read,
  input  wire                           data_valid,
  input  wire cgra_data_pkg::mem_word_t read_data,
  input  wire                           pop,
  output logic                          request_read,
  output logic                          available_pop,
  output cgra_data_pkg::item_t          data_out
);
  import cgra_data_pkg::*;

  localparam int ITEMS = `CGRA_MEM_W / `CGRA_ITEM_W;
  localparam int AW = $clog2(`CGRA_FIFO_DEPTH);

  item_t mem [`CGRA_FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0] count;
  logic pending;
  logic room;

  // A request must leave room for the whole word it brings back.
  assign room = (count <= (AW+1)'(`CGRA_FIFO_DEPTH - ITEMS));
  assign request_read = en && available_read && !pending && room;
  assign available_pop = (count != '0);
  assign data_out = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (request_read) begin
      pending <= 1'b1;
    end else if (data_valid) begin
      pending <= 1'b0;
    end
  end

  // Item 0 sits at the lowest address, so it leaves first.
  always_ff @(posedge clk) begin
    if (data_valid) begin
      for (int j = 0; j < ITEMS; j++) begin
        mem[wr_ptr + AW'(j)] <= read_data[j*`CGRA_ITEM_W +: `CGRA_ITEM_W];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (data_valid) begin
        wr_ptr <= wr_ptr + AW'(ITEMS);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({data_valid, pop})
        2'b10:   count <= count + (AW+1)'(ITEMS);
        2'b11:   count <= count + (AW+1)'(ITEMS - 1);
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Each returned word answers a request made earlier by this block.
  assert property (@(posedge clk) disable iff (!rst_n) data_valid |-> pending)
    else $error("fetch_data: read data valid with no request outstanding");

endmodule

`default_nettype wire

// ==== dispatch_data.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module dispatch_data (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       available_write,
  input  wire                       push,
  input  wire cgra_data_pkg::item_t data_in,
  output logic                      request_write,
  output cgra_data_pkg::mem_word_t  write_data,
  output logic                      available_push
);
  import cgra_data_pkg::*;

  localparam int ITEMS = `CGRA_MEM_W / `CGRA_ITEM_W;
  localparam int CW = $clog2(ITEMS + 1);

  mem_word_t pack;
  logic [CW-1:0] count;
  logic full;

  assign full = (count == CW'(ITEMS));
  assign request_write = full && available_write;
  // The write empties the packer, so a push can land in the same cycle.
  assign available_push = !full || available_write;
  assign write_data = pack;

  // New items enter at the top and drift down.
  // Item 0 ends in the low bits.
  always_ff @(posedge clk) begin
    if (push) begin
      pack <= {data_in, pack[`CGRA_MEM_W-1:`CGRA_ITEM_W]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({request_write, push})
        2'b10:   count <= '0;
        2'b11:   count <= CW'(1);
        2'b01:   count <= count + 1'b1;
        default: count <= count;
      endcase
    end
  end

  // The fabric only pushes into a lane that has room.
  assert property (@(posedge clk) disable iff (!rst_n) push |-> available_push)
    else $error("dispatch_data: push while packer full");

endmodule

`default_nettype wire

// ==== cgra_control_conf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module cgra_control_conf (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           start,
  input  wire                           available_read,
  input  wire                           rd_data_valid,
  input  wire cgra_data_pkg::mem_word_t rd_data,
  output logic                          req_rd_data,
  output cgra_cfg_pkg::ch_mask_t        read_fifo_mask,
  output cgra_cfg_pkg::ch_mask_t        write_fifo_mask,
  output logic                          done,
  fabric_ctrl_if.conf                   ctrl
);
  import cgra_data_pkg::*;

  conf_state_e state;
  logic word_sel;

  assign req_rd_data = (state == CONF_REQ) && available_read;
  assign done = (state == CONF_DONE);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state           <= CONF_IDLE;
      word_sel        <= 1'b0;
      read_fifo_mask  <= '0;
      write_fifo_mask <= '0;
      ctrl.cfg_valid  <= 1'b0;
    end else if (start) begin
      state          <= CONF_REQ;
      word_sel       <= 1'b0;
      ctrl.cfg_valid <= 1'b0;
    end else begin
      case (state)
        CONF_REQ: begin
          if (available_read) begin
            state <= CONF_WAIT;
          end
        end
        CONF_WAIT: begin
          if (rd_data_valid) begin
            if (!word_sel) begin
              // Word 0 carries both channel masks.
              read_fifo_mask  <= rd_data[`CGRA_NUM_CH-1:0];
              write_fifo_mask <= rd_data[2*`CGRA_NUM_CH-1:`CGRA_NUM_CH];
              word_sel        <= 1'b1;
              state           <= CONF_REQ;
            end else begin
              ctrl.cfg_valid <= 1'b1;
              state          <= CONF_DONE;
            end
          end
        end
        CONF_DONE: state <= CONF_IDLE;
        default:   state <= CONF_IDLE;
      endcase
    end
  end

  // Word 1 holds PE k in bits 16k+15:16k.
  always_ff @(posedge clk) begin
    if ((state == CONF_WAIT) && rd_data_valid && word_sel) begin
      ctrl.pe_cfg <= rd_data;
    end
  end

endmodule

`default_nettype wire

// ==== cgra_control_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module cgra_control_exec (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         start,
  input  wire cgra_cfg_pkg::ch_mask_t read_fifo_mask,
  input  wire cgra_cfg_pkg::ch_mask_t write_fifo_mask,
  input  wire [`CGRA_NUM_CH-1:0]      read_fifo_done,
  input  wire [`CGRA_NUM_CH-1:0]      write_fifo_done,
  input  wire [`CGRA_NUM_CH-1:0]      fifo_empty,
  output logic [`CGRA_NUM_CH-1:0]     en_fetch_data,
  output logic                        done,
  fabric_ctrl_if.exec                 ctrl
);
  import cgra_data_pkg::*;

  exec_state_e state;
  logic rd_all_done;
  logic wr_all_done;
  logic drained;

  // Channels outside a mask count as finished.
  assign rd_all_done = &(read_fifo_done | ~read_fifo_mask);
  assign wr_all_done = &(write_fifo_done | ~write_fifo_mask);
  assign drained = (&fifo_empty) && ctrl.fabric_idle;

  assign en_fetch_data = (state == EXEC_RUN) ? read_fifo_mask : '0;
  assign ctrl.fabric_en = (state == EXEC_RUN) || (state == EXEC_DRAIN);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= EXEC_IDLE;
      done  <= 1'b0;
    end else if (start) begin
      state <= EXEC_RUN;
      done  <= 1'b0;
    end else begin
      case (state)
        EXEC_RUN: begin
          if (rd_all_done) begin
            state <= EXEC_DRAIN;
          end
        end
        EXEC_DRAIN: begin
          if (drained) begin
            state <= EXEC_DONE;
          end
        end
        EXEC_DONE: begin
          if (wr_all_done) begin
            done <= 1'b1;
          end
        end
        default: state <= state;
      endcase
    end
  end

  // Once drained, no new data reaches the FIFOs or the fabric.
  assert property (@(posedge clk) disable iff (!rst_n) (state == EXEC_DONE) |-> drained)
    else $error("cgra_control_exec: data arrived after the fabric drained");

endmodule

`default_nettype wire

// ==== cgra_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module cgra_fabric (
  input  wire                                        clk,
  input  wire                                        rst_n,
  input  wire [`CGRA_NUM_LANES-1:0]                  available_pop,
  input  wire [`CGRA_NUM_LANES*`CGRA_ITEM_W-1:0]     fifo_in_data,
  input  wire [`CGRA_NUM_LANES-1:0]                  available_push,
  output logic [`CGRA_NUM_LANES-1:0]                 pop,
  output wire [`CGRA_NUM_LANES-1:0]                  fifo_out_we,
  output wire [`CGRA_NUM_LANES*`CGRA_ITEM_W-1:0]     fifo_out_data,
  fabric_ctrl_if.fabric                              ctrl
);
  import cgra_cfg_pkg::*;
  import cgra_data_pkg::*;

  localparam int N = `CGRA_NUM_LANES;
  localparam int SW = $clog2(N);

  wire [N-1:0][SW-1:0] src;
  wire [N-1:0][`CGRA_ITEM_W-1:0] lane_in;
  wire [N-1:0] want;
  logic [N-1:0] fire;
  logic [N-1:0] out_valid;
  item_t [N-1:0] out_data;

  function automatic item_t pe_apply(pe_cfg_t cfg, item_t item);
    item_t k;
    k = item_t'(cfg[15:8]);
    case (cgra_op_e'(cfg[2:0]))
      OP_PASS: return item;
      OP_ADD:  return item + k;
      OP_SUB:  return item - k;
      OP_XOR:  return item ^ k;
      default: return item;
    endcase
  endfunction

  for (genvar k = 0; k < N; k++) begin : g_pe
    assign src[k] = ctrl.pe_cfg[k][4:3];
    assign lane_in[k] = fifo_in_data[src[k]*`CGRA_ITEM_W +: `CGRA_ITEM_W];
    assign fifo_out_we[k] = out_valid[k] && available_push[k];
    assign want[k] = ctrl.fabric_en && ctrl.cfg_valid && available_pop[src[k]] &&
                     (!out_valid[k] || fifo_out_we[k]) && available_push[k];
  end

  // Lower PE index wins when two PEs read the same lane.
  always_comb begin
    fire = '0;
    pop  = '0;
    for (int k = 0; k < N; k++) begin
      if (want[k] && !pop[src[k]]) begin
        fire[k]     = 1'b1;
        pop[src[k]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= '0;
    end else begin
      for (int k = 0; k < N; k++) begin
        if (fire[k]) begin
          out_valid[k] <= 1'b1;
        end else if (fifo_out_we[k]) begin
          out_valid[k] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < N; k++) begin
      if (fire[k]) begin
        out_data[k] <= pe_apply(ctrl.pe_cfg[k], lane_in[k]);
      end
    end
  end

  assign fifo_out_data = out_data;
  assign ctrl.fabric_idle = ~|out_valid;

endmodule

`default_nettype wire

// ==== cgra_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module cgra_acc (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                start,
  input  wire [`CGRA_NUM_CH-1:0]             acc_user_done_rd_data,
  input  wire [`CGRA_NUM_CH-1:0]             acc_user_done_wr_data,
  input  wire [`CGRA_NUM_CH-1:0]             acc_user_available_read,
  output wire [`CGRA_NUM_CH-1:0]             acc_user_request_read,
  input  wire [`CGRA_NUM_CH-1:0]             acc_user_read_data_valid,
  input  wire [`CGRA_NUM_CH*`CGRA_MEM_W-1:0] acc_user_read_data,
  input  wire [`CGRA_NUM_CH-1:0]             acc_user_available_write,
  output wire [`CGRA_NUM_CH-1:0]             acc_user_request_write,
  output wire [`CGRA_NUM_CH*`CGRA_MEM_W-1:0] acc_user_write_data,
  output wire                                acc_user_done
);
  import cgra_cfg_pkg::*;

  wire [`CGRA_NUM_CH-1:0] request_read;
  wire [`CGRA_NUM_CH-1:0] en_fetch_data;
  wire conf_req_rd_data;
  wire conf_done;
  ch_mask_t read_fifo_mask;
  ch_mask_t write_fifo_mask;
  wire [`CGRA_NUM_LANES-1:0] pop;
  wire [`CGRA_NUM_LANES-1:0] available_pop;
  wire [`CGRA_NUM_LANES-1:0] push;
  wire [`CGRA_NUM_LANES-1:0] available_push;
  wire [`CGRA_NUM_LANES*`CGRA_ITEM_W-1:0] fifo_in_data;
  wire [`CGRA_NUM_LANES*`CGRA_ITEM_W-1:0] fifo_out_data;

  fabric_ctrl_if ctrl_if ();

  // Fetch 0 stays off until conf_done, so the two never overlap.
  assign acc_user_request_read =
    request_read | {{(`CGRA_NUM_CH-1){1'b0}}, conf_req_rd_data};

  // Words returned before cfg_valid are configuration words, not fetch data.
  for (genvar ch = 0; ch < `CGRA_NUM_CH; ch++) begin : g_ch
    fetch_data fetch_data_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .en             (en_fetch_data[ch]),
      .available_read (acc_user_available_read[ch]),
      .data_valid     (acc_user_read_data_valid[ch] && ctrl_if.cfg_valid),
      .read_data      (acc_user_read_data[ch*`CGRA_MEM_W +: `CGRA_MEM_W]),
      .pop            (pop[ch]),
      .request_read   (request_read[ch]),
      .available_pop  (available_pop[ch]),
      .data_out       (fifo_in_data[ch*`CGRA_ITEM_W +: `CGRA_ITEM_W])
    );

    dispatch_data dispatch_data_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .available_write (acc_user_available_write[ch]),
      .push            (push[ch]),
      .data_in         (fifo_out_data[ch*`CGRA_ITEM_W +: `CGRA_ITEM_W]),
      .request_write   (acc_user_request_write[ch]),
      .write_data      (acc_user_write_data[ch*`CGRA_MEM_W +: `CGRA_MEM_W]),
      .available_push  (available_push[ch])
    );
  end

  cgra_control_conf control_conf_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .start           (start),
    .available_read  (acc_user_available_read[0]),
    .rd_data_valid   (acc_user_read_data_valid[0]),
    .rd_data         (acc_user_read_data[`CGRA_MEM_W-1:0]),
    .req_rd_data     (conf_req_rd_data),
    .read_fifo_mask  (read_fifo_mask),
    .write_fifo_mask (write_fifo_mask),
    .done            (conf_done),
    .ctrl            (ctrl_if)
  );

  cgra_control_exec control_exec_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .start           (conf_done),
    .read_fifo_mask  (read_fifo_mask),
    .write_fifo_mask (write_fifo_mask),
    .read_fifo_done  (acc_user_done_rd_data),
    .write_fifo_done (acc_user_done_wr_data),
    .fifo_empty      (~available_pop),
    .en_fetch_data   (en_fetch_data),
    .done            (acc_user_done),
    .ctrl            (ctrl_if)
  );

  cgra_fabric fabric_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .available_pop  (available_pop),
    .fifo_in_data   (fifo_in_data),
    .available_push (available_push),
    .pop            (pop),
    .fifo_out_we    (push),
    .fifo_out_data  (fifo_out_data),
    .ctrl           (ctrl_if)
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);
  localparam int HALF_PERIOD = 5;
  localparam int RESET_CYCLES = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Release on a falling edge, like every other input.
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_cgra_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cgra_defs.svh"

module tb_cgra_acc;
  import cgra_cfg_pkg::*;
  import cgra_data_pkg::*;

  localparam int NCH = `CGRA_NUM_CH;
  localparam int MW = `CGRA_MEM_W;
  localparam int IW = `CGRA_ITEM_W;
  localparam int ITEMS = MW / IW;
  localparam int WORDS = 6;
  localparam ch_mask_t RD_MASK = 4'b1011;
  localparam ch_mask_t WR_MASK = 4'b1101;

  logic clk;
  logic rst_n;
  logic start;
  logic [NCH-1:0] done_rd;
  logic [NCH-1:0] done_wr;
  logic [NCH-1:0] avail_rd;
  logic [NCH-1:0] rvalid;
  logic [NCH*MW-1:0] rdata;
  logic [NCH-1:0] avail_wr;
  wire [NCH-1:0] req_rd;
  wire [NCH-1:0] req_wr;
  wire [NCH*MW-1:0] wdata;
  wire acc_done;

  integer seed;
  int mismatch_errors;
  int other_errors;
  logic started;
  bit done_seen;

  cgra_op_e pe_op [NCH];
  logic [1:0] pe_src [NCH];
  logic [7:0] pe_const [NCH];
  mem_word_t cfg_words [2];
  int cfg_reqs;
  int cfg_resp;

  // Host memory model state, one entry per channel.
  mem_word_t rd_words [NCH][WORDS];
  int rd_issued [NCH];
  int rd_returned [NCH];
  int wr_count [NCH];
  logic resp_busy [NCH];
  logic resp_is_cfg [NCH];
  int resp_delay [NCH];
  mem_word_t resp_word [NCH];

  wire flags_done = (&(done_rd | ~RD_MASK)) && (&(done_wr | ~WR_MASK));

  tb_clock_gen clock_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  cgra_acc cgra_acc_i (
    .clk                      (clk),
    .rst_n                    (rst_n),
    .start                    (start),
    .acc_user_done_rd_data    (done_rd),
    .acc_user_done_wr_data    (done_wr),
    .acc_user_available_read  (avail_rd),
    .acc_user_request_read    (req_rd),
    .acc_user_read_data_valid (rvalid),
    .acc_user_read_data       (rdata),
    .acc_user_available_write (avail_wr),
    .acc_user_request_write   (req_wr),
    .acc_user_write_data      (wdata),
    .acc_user_done            (acc_done)
  );

  function automatic item_t transform_item(cgra_op_e op, logic [7:0] k, item_t item);
    item_t kx;
    kx = {8'h00, k};
    case (op)
      OP_ADD:  return item + kx;
      OP_SUB:  return item - kx;
      OP_XOR:  return item ^ kx;
      default: return item;
    endcase
  endfunction

  task automatic accept_read_request(input int ch);
    mem_word_t word;
    if (resp_busy[ch]) begin
      other_errors++;
      $display("Channel %0d sent a read request while one was outstanding at %0t", ch, $time);
    end
    resp_is_cfg[ch] = (ch == 0) && (cfg_reqs < 2);
    if (resp_is_cfg[ch]) begin
      word = cfg_words[cfg_reqs];
      cfg_reqs++;
    end else begin
      word[31:0] = $random(seed);
      word[63:32] = $random(seed);
      if (rd_issued[ch] < WORDS) begin
        rd_words[ch][rd_issued[ch]] = word;
      end else begin
        other_errors++;
        $display("Channel %0d read more words than the host offered", ch);
      end
      rd_issued[ch]++;
    end
    resp_word[ch] = word;
    resp_busy[ch] = 1'b1;
    resp_delay[ch] = 1 + ($random(seed) & 3);
  endtask

  // Write word n of channel k is read word n of its source lane, item by item.
  task automatic check_write_word(input int ch);
    int src;
    int n;
    mem_word_t got;
    mem_word_t exp;
    got = wdata[ch*MW +: MW];
    n = wr_count[ch];
    src = pe_src[ch];
    if (n >= WORDS || n >= rd_issued[src]) begin
      other_errors++;
      $display("Channel %0d wrote a word with no source data behind it", ch);
    end else begin
      for (int j = 0; j < ITEMS; j++) begin
        exp[j*IW +: IW] = transform_item(pe_op[ch], pe_const[ch], rd_words[src][n][j*IW +: IW]);
      end
      assert (got == exp) else begin
        mismatch_errors++;
        $display("MISMATCH at %0t: channel %0d word %0d got %h expected %h",
                 $time, ch, n, got, exp);
      end
    end
    wr_count[ch]++;
  endtask

  task automatic wait_for_reset_release(input int limit, output bit ok);
    int n;
    n = 0;
    ok = rst_n;
    while (!ok && n < limit) begin
      @(negedge clk);
      n++;
      ok = rst_n;
    end
  endtask

  task automatic wait_for_done(input int limit, output bit ok);
    int n;
    n = 0;
    ok = 1'b0;
    while (!ok && n < limit) begin
      @(negedge clk);
      n++;
      ok = acc_done;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      for (int ch = 0; ch < NCH; ch++) begin
        if (req_rd[ch]) begin
          accept_read_request(ch);
        end
        if (req_wr[ch]) begin
          check_write_word(ch);
        end
      end
    end
  end

  // Responses, done flags and random availability change on the falling edge.
  always @(negedge clk) begin
    for (int ch = 0; ch < NCH; ch++) begin
      rvalid[ch] = 1'b0;
      done_rd[ch] = RD_MASK[ch] && (rd_returned[ch] >= WORDS);
      done_wr[ch] = WR_MASK[ch] && (wr_count[ch] >= WORDS);
      if (resp_busy[ch]) begin
        resp_delay[ch]--;
        if (resp_delay[ch] == 0) begin
          rvalid[ch] = 1'b1;
          rdata[ch*MW +: MW] = resp_word[ch];
          resp_busy[ch] = 1'b0;
          if (resp_is_cfg[ch]) begin
            cfg_resp++;
          end else begin
            rd_returned[ch]++;
          end
        end
      end
      avail_rd[ch] = (($random(seed) & 3) != 0) && (rd_issued[ch] < WORDS);
      avail_wr[ch] = (($random(seed) & 3) != 0);
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
      !started |-> (req_rd == '0 && req_wr == '0 && !acc_done))
    else begin
      other_errors++;
      $display("Request or done seen before start at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n)
      (started && cfg_resp < 2) |-> (req_rd[NCH-1:1] == '0 && req_wr == '0))
    else begin
      other_errors++;
      $display("Traffic besides the configuration reads at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n) (req_rd & ~RD_MASK) == '0)
    else begin
      other_errors++;
      $display("Read request on a channel outside the read mask at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n) (req_wr & ~WR_MASK) == '0)
    else begin
      other_errors++;
      $display("Write on a channel outside the write mask at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n) (req_wr & ~avail_wr) == '0)
    else begin
      other_errors++;
      $display("Write request while the channel was not available at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n) (req_rd & ~avail_rd) == '0)
    else begin
      other_errors++;
      $display("Read request while the channel was not available at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n) acc_done |-> flags_done)
    else begin
      other_errors++;
      $display("Accelerator done before every masked done flag at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (!rst_n) acc_done |=> acc_done)
    else begin
      other_errors++;
      $display("Accelerator done dropped at %0t", $time);
    end

  initial begin
    bit ok;
    seed = 59;
    mismatch_errors = 0;
    other_errors = 0;
    started = 1'b0;
    start = 1'b0;
    done_rd = '0;
    done_wr = '0;
    avail_rd = '0;
    avail_wr = '0;
    rvalid = '0;
    rdata = '0;
    cfg_reqs = 0;
    cfg_resp = 0;
    for (int ch = 0; ch < NCH; ch++) begin
      rd_issued[ch] = 0;
      rd_returned[ch] = 0;
      wr_count[ch] = 0;
      resp_busy[ch] = 1'b0;
      resp_is_cfg[ch] = 1'b0;
      resp_delay[ch] = 0;
      resp_word[ch] = '0;
    end

    // Lane 2 is not read, so PE 1 stays idle and channel 1 never writes.
    pe_op = '{OP_ADD, OP_PASS, OP_XOR, OP_SUB};
    pe_src = '{2'd1, 2'd2, 2'd3, 2'd0};
    pe_const = '{8'h25, 8'h00, 8'hA5, 8'h3C};
    cfg_words[0] = {{(MW-2*NCH){1'b0}}, WR_MASK, RD_MASK};
    for (int k = 0; k < NCH; k++) begin
      cfg_words[1][k*IW +: IW] = {pe_const[k], 3'b000, pe_src[k], pe_op[k]};
    end

    wait_for_reset_release(100, ok);
    if (!ok) begin
      other_errors++;
      $display("Reset was never released");
    end
    repeat (5) @(negedge clk);
    start = 1'b1;
    started = 1'b1;
    @(negedge clk);
    start = 1'b0;

    wait_for_done(5000, done_seen);
    if (!done_seen) begin
      other_errors++;
      $display("Timed out waiting for accelerator done");
    end
    repeat (20) @(negedge clk);

    assert (cfg_reqs == 2) else begin
      other_errors++;
      $display("Configuration took %0d reads instead of 2", cfg_reqs);
    end
    for (int ch = 0; ch < NCH; ch++) begin
      if (WR_MASK[ch]) begin
        assert (wr_count[ch] == WORDS) else begin
          other_errors++;
          $display("Channel %0d wrote %0d words instead of %0d", ch, wr_count[ch], WORDS);
        end
      end
    end

    $display("Errors: %0d mismatches, %0d other", mismatch_errors, other_errors);
    if (mismatch_errors + other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+.
cgra_cfg_pkg.sv
cgra_data_pkg.sv
fabric_ctrl_if.sv
fetch_data.sv
dispatch_data.sv
cgra_control_conf.sv
cgra_control_exec.sv
cgra_fabric.sv
cgra_acc.sv
tb_clock_gen.sv
tb_cgra_acc.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_cgra_acc
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sim.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
